// File: source/conv_pkg.sv
package conv_pkg;

    // cluster and datapath sizes
    localparam int NUM_PE    = 4;
    localparam int LANES     = 4;
    localparam int OUT_SHIFT = 6;

    // buffer geometry
    localparam int IFM_DEPTH = 1024;
    localparam int IFM_AW    = $clog2(IFM_DEPTH);
    localparam int W_DEPTH   = 64;
    localparam int W_AW      = $clog2(W_DEPTH);

    typedef logic signed [7:0] sbyte_t;

    // four signed channels per 32-bit word, lane 0 in the low byte
    typedef sbyte_t [LANES-1:0] word_t;
    typedef word_t [NUM_PE-1:0] weight_bank_t;
    typedef sbyte_t [NUM_PE-1:0] ofm_t;

    typedef enum logic [1:0] {
        OP_NOP,
        OP_LOAD_IFM,
        OP_LOAD_WEIGHT,
        OP_RUN
    } opcode_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD_IFM,
        ST_LOAD_WEIGHT,
        ST_RUN
    } ctl_state_t;

    typedef struct packed {
        logic [7:0] ofm_pixels;
        logic [3:0] ifm_words;
        logic [2:0] tiles;
    } conv_cfg_t;

    typedef struct packed {
        logic              ifm_en;
        logic              weight_en;
        logic [IFM_AW-1:0] addr;
    } buf_wr_t;

    typedef struct packed {
        logic              valid;
        logic [IFM_AW-1:0] ifm_addr;
        logic [W_AW-1:0]   weight_addr;
        logic              first;
        logic              last;
        logic              run_last;
        logic [7:0]        pixel;
        logic [2:0]        tile;
    } rd_req_t;

endpackage

// File: source/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cmd_valid,
    input  conv_pkg::opcode_t   cmd,
    input  conv_pkg::conv_cfg_t cfg,
    input  logic                load_valid,
    input  logic                done,
    output logic                busy,
    output logic                start,
    output conv_pkg::buf_wr_t   buf_wr
);
    import conv_pkg::*;

    ctl_state_t        state;
    logic [IFM_AW-1:0] load_cnt;
    logic [11:0]       load_size;
    logic              load_last;
    logic              run_started;

    // number of strobes the current load expects
    always_comb begin
        if (state == ST_LOAD_IFM) begin
            load_size = 12'(cfg.ofm_pixels) * 12'(cfg.ifm_words);
        end else begin
            load_size = 12'(cfg.tiles) * 12'(cfg.ifm_words);
        end
    end

    assign load_last = (12'(load_cnt) == load_size - 12'd1);
    assign busy      = (state != ST_IDLE);

    always_comb begin
        buf_wr.ifm_en    = (state == ST_LOAD_IFM) && load_valid;
        buf_wr.weight_en = (state == ST_LOAD_WEIGHT) && load_valid;
        buf_wr.addr      = load_cnt;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ST_IDLE;
            load_cnt    <= '0;
            run_started <= 1'b0;
            start       <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    load_cnt    <= '0;
                    run_started <= 1'b0;
                    if (cmd_valid) begin
                        case (cmd)
                            OP_LOAD_IFM:    state <= ST_LOAD_IFM;
                            OP_LOAD_WEIGHT: state <= ST_LOAD_WEIGHT;
                            OP_RUN:         state <= ST_RUN;
                            default:        state <= ST_IDLE;
                        endcase
                    end
                end
                ST_LOAD_IFM, ST_LOAD_WEIGHT: begin
                    if (load_valid) begin
                        load_cnt <= load_cnt + 1'b1;
                        if (load_last) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_RUN: begin
                    // single start pulse, one cycle after busy rises
                    if (!run_started) begin
                        start       <= 1'b1;
                        run_started <= 1'b1;
                    end
                    if (done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/feature_buffer.sv
`timescale 1ns/1ps

module feature_buffer (
    input  logic                          clk,
    input  conv_pkg::buf_wr_t             wr,
    input  conv_pkg::word_t               wr_data,
    input  logic [conv_pkg::IFM_AW-1:0]   rd_addr,
    output conv_pkg::word_t               rd_data
);
    import conv_pkg::*;

    word_t mem [IFM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr.ifm_en) begin
            mem[wr.addr] <= wr_data;
        end
    end

    // registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: source/weight_buffer.sv
`timescale 1ns/1ps

module weight_buffer (
    input  logic                         clk,
    input  conv_pkg::buf_wr_t            wr,
    input  conv_pkg::weight_bank_t       wr_data,
    input  logic [conv_pkg::W_AW-1:0]    rd_addr,
    output conv_pkg::weight_bank_t       rd_data
);
    import conv_pkg::*;

    logic [W_AW-1:0] wr_addr;

    // bank depth is smaller than the shared write address
    assign wr_addr = wr.addr[W_AW-1:0];

    for (genvar b = 0; b < NUM_PE; b++) begin : g_bank
        word_t mem [W_DEPTH];

        always_ff @(posedge clk) begin
            if (wr.weight_en) begin
                mem[wr_addr] <= wr_data[b];
            end
        end

        always_ff @(posedge clk) begin
            rd_data[b] <= mem[rd_addr];
        end
    end

endmodule

// File: source/address_generator.sv
`timescale 1ns/1ps

module address_generator (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  conv_pkg::conv_cfg_t cfg,
    output conv_pkg::rd_req_t   req
);
    import conv_pkg::*;

    logic              active;
    logic [3:0]        word_cnt;
    logic [7:0]        pixel_cnt;
    logic [2:0]        tile_cnt;
    logic [IFM_AW-1:0] ifm_addr;
    logic [W_AW-1:0]   w_addr;
    logic [W_AW-1:0]   w_base;
    logic [W_AW-1:0]   w_stride;
    logic              word_last;
    logic              pixel_last;
    logic              tile_last;

    assign w_stride   = W_AW'(cfg.ifm_words);
    assign word_last  = (word_cnt == cfg.ifm_words - 4'd1);
    assign pixel_last = (pixel_cnt == cfg.ofm_pixels - 8'd1);
    assign tile_last  = (tile_cnt == cfg.tiles - 3'd1);

    always_comb begin
        req.valid       = active;
        req.ifm_addr    = ifm_addr;
        req.weight_addr = w_addr;
        req.first       = active && (word_cnt == 4'd0);
        req.last        = active && word_last;
        req.run_last    = active && word_last && pixel_last && tile_last;
        req.pixel       = pixel_cnt;
        req.tile        = tile_cnt;
    end

    // loop order is tile, then pixel, then word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active    <= 1'b0;
            word_cnt  <= '0;
            pixel_cnt <= '0;
            tile_cnt  <= '0;
            ifm_addr  <= '0;
            w_addr    <= '0;
            w_base    <= '0;
        end else if (start) begin
            active    <= 1'b1;
            word_cnt  <= '0;
            pixel_cnt <= '0;
            tile_cnt  <= '0;
            ifm_addr  <= '0;
            w_addr    <= '0;
            w_base    <= '0;
        end else if (active) begin
            if (!word_last) begin
                word_cnt <= word_cnt + 4'd1;
                ifm_addr <= ifm_addr + 1'b1;
                w_addr   <= w_addr + 1'b1;
            end else begin
                word_cnt <= '0;
                if (!pixel_last) begin
                    // pixels sit back to back in the feature buffer
                    pixel_cnt <= pixel_cnt + 8'd1;
                    ifm_addr  <= ifm_addr + 1'b1;
                    w_addr    <= w_base;
                end else begin
                    pixel_cnt <= '0;
                    ifm_addr  <= '0;
                    if (tile_last) begin
                        active   <= 1'b0;
                        tile_cnt <= '0;
                        w_base   <= '0;
                        w_addr   <= '0;
                    end else begin
                        tile_cnt <= tile_cnt + 3'd1;
                        w_base   <= w_base + w_stride;
                        w_addr   <= w_base + w_stride;
                    end
                end
            end
        end
    end

endmodule

// File: source/pe.sv
`timescale 1ns/1ps

module pe (
    input  logic              clk,
    input  logic              arst_n,
    input  conv_pkg::word_t   act,
    input  conv_pkg::word_t   weight,
    input  logic              acc_en,
    input  logic              first,
    input  logic              last,
    output logic signed [7:0] result
);
    import conv_pkg::*;

    logic signed [31:0] dot;
    logic signed [31:0] acc;
    logic signed [31:0] sum;
    logic signed [31:0] scaled;
    logic signed [7:0]  relu;

    // signed dot product over the lanes of one word
    always_comb begin
        dot = '0;
        for (int i = 0; i < LANES; i++) begin
            dot += 32'($signed(act[i]) * $signed(weight[i]));
        end
    end

    always_comb begin
        sum    = first ? dot : acc + dot;
        scaled = sum >>> OUT_SHIFT;
        if (sum < 0) begin
            relu = '0;
        end else if (scaled > 32'sd127) begin
            relu = 8'sd127;
        end else begin
            relu = scaled[7:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc    <= '0;
            result <= '0;
        end else if (acc_en) begin
            acc <= sum;
            // final word of the pixel, clamp and keep
            if (last) begin
                result <= relu;
            end
        end
    end

endmodule

// File: source/pe_cluster.sv
`timescale 1ns/1ps

module pe_cluster (
    input  logic                   clk,
    input  logic                   arst_n,
    input  conv_pkg::rd_req_t      req,
    input  conv_pkg::word_t        ifm_data,
    input  conv_pkg::weight_bank_t weight_data,
    output logic                   ofm_valid,
    output conv_pkg::ofm_t         ofm,
    output logic [7:0]             ofm_pixel,
    output logic [2:0]             ofm_tile,
    output logic                   done
);
    import conv_pkg::*;

    logic       tag_valid;
    logic       tag_first;
    logic       tag_last;
    logic       tag_run_last;
    logic [7:0] tag_pixel;
    logic [2:0] tag_tile;

    // tags wait one cycle for the buffer read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_valid    <= 1'b0;
            tag_first    <= 1'b0;
            tag_last     <= 1'b0;
            tag_run_last <= 1'b0;
            ofm_valid    <= 1'b0;
            done         <= 1'b0;
        end else begin
            tag_valid    <= req.valid;
            tag_first    <= req.first;
            tag_last     <= req.last;
            tag_run_last <= req.run_last;
            ofm_valid    <= tag_valid && tag_last;
            done         <= tag_valid && tag_run_last;
        end
    end

    always_ff @(posedge clk) begin
        tag_pixel <= req.pixel;
        tag_tile  <= req.tile;
        if (tag_valid && tag_last) begin
            ofm_pixel <= tag_pixel;
            ofm_tile  <= tag_tile;
        end
    end

    // one element per output channel of the tile
    for (genvar k = 0; k < NUM_PE; k++) begin : g_pe
        pe u_pe (
            .clk    (clk),
            .arst_n (arst_n),
            .act    (ifm_data),
            .weight (weight_data[k]),
            .acc_en (tag_valid),
            .first  (tag_first),
            .last   (tag_last),
            .result (ofm[k])
        );
    end

endmodule

// File: source/conv_top.sv
`timescale 1ns/1ps

module conv_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   cmd_valid,
    input  conv_pkg::opcode_t      cmd,
    input  conv_pkg::conv_cfg_t    cfg,
    input  logic                   load_valid,
    input  conv_pkg::word_t        load_ifm,
    input  conv_pkg::weight_bank_t load_weight,
    output logic                   busy,
    output logic                   ofm_valid,
    output conv_pkg::ofm_t         ofm,
    output logic [7:0]             ofm_pixel,
    output logic [2:0]             ofm_tile,
    output logic                   done
);
    import conv_pkg::*;

    logic         start;
    buf_wr_t      buf_wr;
    rd_req_t      req;
    word_t        ifm_data;
    weight_bank_t weight_data;

    control_unit u_control_unit (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cfg        (cfg),
        .load_valid (load_valid),
        .done       (done),
        .busy       (busy),
        .start      (start),
        .buf_wr     (buf_wr)
    );

    feature_buffer u_feature_buffer (
        .clk     (clk),
        .wr      (buf_wr),
        .wr_data (load_ifm),
        .rd_addr (req.ifm_addr),
        .rd_data (ifm_data)
    );

    weight_buffer u_weight_buffer (
        .clk     (clk),
        .wr      (buf_wr),
        .wr_data (load_weight),
        .rd_addr (req.weight_addr),
        .rd_data (weight_data)
    );

    address_generator u_address_generator (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .cfg    (cfg),
        .req    (req)
    );

    pe_cluster u_pe_cluster (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .ifm_data    (ifm_data),
        .weight_data (weight_data),
        .ofm_valid   (ofm_valid),
        .ofm         (ofm),
        .ofm_pixel   (ofm_pixel),
        .ofm_tile    (ofm_tile),
        .done        (done)
    );

endmodule

// File: verif/conv_asserts.sv
`timescale 1ns/1ps

module conv_asserts (
    input logic clk,
    input logic arst_n,
    input logic cmd_valid,
    input logic busy,
    input logic ofm_valid,
    input logic done
);

    int unsigned fail_count = 0;
    logic        cmd_seen;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_seen <= 1'b0;
        end else if (cmd_valid) begin
            cmd_seen <= 1'b1;
        end
    end

    // everything quiet between reset and the first command
    quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
        !cmd_seen |-> !busy && !ofm_valid && !done)
        else begin
            fail_count++;
            $error("busy, ofm_valid or done high before the first command");
        end

    done_with_ofm: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> ofm_valid)
        else begin
            fail_count++;
            $error("done without ofm_valid");
        end

    // busy drops the cycle after done, and done is a single pulse
    busy_falls_after_done: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !busy && !done)
        else begin
            fail_count++;
            $error("busy or done still high one cycle after done");
        end

    ofm_only_while_busy: assert property (@(posedge clk) disable iff (!arst_n)
        ofm_valid |-> busy)
        else begin
            fail_count++;
            $error("ofm_valid while not busy");
        end

endmodule

bind conv_top conv_asserts u_conv_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .ofm_valid (ofm_valid),
    .done      (done)
);

// File: verif/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;
    import conv_pkg::*;

    // a few thousand cycles cover every load and run below
    localparam int CYCLE_LIMIT = 20000;

    typedef struct packed {
        ofm_t       ofm;
        logic [7:0] pixel;
        logic [2:0] tile;
    } ofm_beat_t;

    logic         clk;
    logic         arst_n;
    logic         cmd_valid;
    opcode_t      cmd;
    conv_cfg_t    cfg;
    logic         load_valid;
    word_t        load_ifm;
    weight_bank_t load_weight;
    logic         busy;
    logic         ofm_valid;
    ofm_t         ofm;
    logic [7:0]   ofm_pixel;
    logic [2:0]   ofm_tile;
    logic         done;

    logic [31:0]  lcg_state = 32'h8f1dca7b;
    int           cycle_count = 0;
    int           done_count = 0;
    ofm_beat_t    expected[$];

    // mirrors of what the testbench wrote into the buffers
    word_t        ifm_mem [IFM_DEPTH];
    weight_bank_t w_mem [W_DEPTH];

    conv_top u_conv_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .cfg         (cfg),
        .load_valid  (load_valid),
        .load_ifm    (load_ifm),
        .load_weight (load_weight),
        .busy        (busy),
        .ofm_valid   (ofm_valid),
        .ofm         (ofm),
        .ofm_pixel   (ofm_pixel),
        .ofm_tile    (ofm_tile),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_failure(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    // dot product over words and lanes, then ReLU, shift and clamp
    function automatic ofm_t expected_ofm(input int pixel, input int tile, input conv_cfg_t c);
        ofm_t res;
        int   acc;
        int   words;
        words = int'(c.ifm_words);
        for (int k = 0; k < NUM_PE; k++) begin
            acc = 0;
            for (int w = 0; w < words; w++) begin
                for (int i = 0; i < LANES; i++) begin
                    acc += int'(ifm_mem[pixel*words+w][i]) * int'(w_mem[tile*words+w][k][i]);
                end
            end
            if (acc < 0) begin
                res[k] = 8'sd0;
            end else if ((acc >>> OUT_SHIFT) > 127) begin
                res[k] = 8'sd127;
            end else begin
                res[k] = 8'(acc >>> OUT_SHIFT);
            end
        end
        return res;
    endfunction

    task automatic predict_run(input conv_cfg_t c);
        for (int t = 0; t < int'(c.tiles); t++) begin
            for (int p = 0; p < int'(c.ofm_pixels); p++) begin
                expected.push_back('{ofm: expected_ofm(p, t, c), pixel: 8'(p), tile: 3'(t)});
            end
        end
    endtask

    task automatic send_cmd(input opcode_t op, input conv_cfg_t c);
        @(negedge clk);
        cfg       = c;
        cmd       = op;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd       = OP_NOP;
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk);
    endtask

    task automatic load_features(input conv_cfg_t c);
        int n;
        n = int'(c.ofm_pixels) * int'(c.ifm_words);
        send_cmd(OP_LOAD_IFM, c);
        for (int i = 0; i < n; i++) begin
            load_ifm   = ifm_mem[i];
            load_valid = 1'b1;
            @(negedge clk);
        end
        load_valid = 1'b0;
        wait_idle();
    endtask

    task automatic load_weights(input conv_cfg_t c);
        int n;
        n = int'(c.tiles) * int'(c.ifm_words);
        send_cmd(OP_LOAD_WEIGHT, c);
        for (int i = 0; i < n; i++) begin
            load_weight = w_mem[i];
            load_valid  = 1'b1;
            @(negedge clk);
        end
        load_valid = 1'b0;
        wait_idle();
    endtask

    task automatic fill_features(input conv_cfg_t c);
        for (int i = 0; i < int'(c.ofm_pixels) * int'(c.ifm_words); i++) begin
            ifm_mem[i] = next_random();
        end
    endtask

    task automatic run_conv(input conv_cfg_t c, input bit intrude);
        int done_base;
        done_base = done_count;
        send_cmd(OP_RUN, c);
        if (intrude) begin
            assert (busy) else report_failure("busy still low after the run command");
            // load command and strobes while busy leave the feature buffer untouched
            repeat (3) begin
                cmd        = OP_LOAD_IFM;
                cmd_valid  = 1'b1;
                load_ifm   = next_random();
                load_valid = 1'b1;
                @(negedge clk);
            end
            cmd        = OP_NOP;
            cmd_valid  = 1'b0;
            load_valid = 1'b0;
        end
        while (!done) @(negedge clk);
        @(negedge clk);
        assert (expected.size() == 0)
            else report_failure($sformatf("%0d predicted outputs never came", expected.size()));
        assert (done_count - done_base == 1)
            else report_failure($sformatf("done pulsed %0d times", done_count - done_base));
        wait_idle();
    endtask

    // output monitor on the falling edge where outputs are stable
    always @(negedge clk) begin
        ofm_beat_t exp_beat;
        if (arst_n && ofm_valid) begin
            if (expected.size() == 0) begin
                report_failure("output strobe with no prediction pending");
            end else begin
                exp_beat = expected.pop_front();
                assert (ofm == exp_beat.ofm)
                    else report_failure($sformatf("ofm %h, expected %h", ofm, exp_beat.ofm));
                assert (ofm_pixel == exp_beat.pixel)
                    else report_failure($sformatf("ofm_pixel %0d, expected %0d",
                                                  ofm_pixel, exp_beat.pixel));
                assert (ofm_tile == exp_beat.tile)
                    else report_failure($sformatf("ofm_tile %0d, expected %0d",
                                                  ofm_tile, exp_beat.tile));
            end
        end
        if (arst_n && done) begin
            done_count++;
        end
        assert (u_conv_top.u_conv_asserts.fail_count == 0)
            else report_failure("a bound protocol assertion on the top level fired");
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        conv_cfg_t c;
        int        cap;
        arst_n      = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = OP_NOP;
        cfg         = '0;
        load_valid  = 1'b0;
        load_ifm    = '0;
        load_weight = '0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        repeat (3) @(negedge clk);

        // saturating and negative sums with hand-worked expected values
        c = '{ofm_pixels: 8'd2, ifm_words: 4'd1, tiles: 3'd1};
        w_mem[0][0] = {4{8'h7f}};
        w_mem[0][1] = {4{8'h01}};
        w_mem[0][2] = {4{8'h80}};
        w_mem[0][3] = {8'sd0, 8'sd50, -8'sd100, 8'sd100};
        ifm_mem[0]  = {4{8'h7f}};
        ifm_mem[1]  = {4{8'h80}};
        load_weights(c);
        load_features(c);
        expected.push_back('{ofm: {8'sd99, 8'sd0, 8'sd7, 8'sd127}, pixel: 8'd0, tile: 3'd0});
        expected.push_back('{ofm: {8'sd0, 8'sd127, 8'sd0, 8'sd0}, pixel: 8'd1, tile: 3'd0});
        run_conv(c, 1'b0);

        // random weights over 63 entries cover any later config
        c = '{ofm_pixels: 8'd1, ifm_words: 4'd9, tiles: 3'd7};
        for (int a = 0; a < 63; a++) begin
            for (int k = 0; k < NUM_PE; k++) begin
                w_mem[a][k] = next_random();
            end
        end
        load_weights(c);

        c = '{ofm_pixels: 8'd4, ifm_words: 4'd2, tiles: 3'd2};
        fill_features(c);
        load_features(c);
        predict_run(c);
        run_conv(c, 1'b1);

        // random shape on the weights already loaded
        c.ifm_words  = 4'(32'd1 + next_random() % 32'd15);
        cap          = 63 / int'(c.ifm_words);
        if (cap > 7) begin
            cap = 7;
        end
        c.tiles      = 3'(32'd1 + next_random() % 32'(cap));
        c.ofm_pixels = 8'(32'd1 + next_random() % 32'd24);
        fill_features(c);
        load_features(c);
        predict_run(c);
        run_conv(c, 1'b0);

        repeat (3) @(negedge clk);
        if (u_conv_top.u_conv_asserts.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
source/conv_pkg.sv
source/control_unit.sv
source/feature_buffer.sv
source/weight_buffer.sv
source/address_generator.sv
source/pe.sv
source/pe_cluster.sv
source/conv_top.sv
verif/conv_asserts.sv
verif/conv_tb.sv

// File: Makefile
SIM = obj_dir/conv_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module conv_tb -o conv_sim
	@out="$$(./$(SIM) +verilator+error+limit+100 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
